// ==== hci_subsys_pkg.sv ====
// Bus sizes, channel numbering, bus opcodes and FSM state types of the shared-memory subsystem.
package hci_subsys_pkg;

  // Bus geometry.
  localparam int unsigned AW        = 12;            // Byte address, 4 KiB bank.
  localparam int unsigned DW        = 32;            // Data word.
  localparam int unsigned BW        = 8;             // One byte lane.
  localparam int unsigned BE_W      = DW / BW;       // Byte enables per word.
  localparam int unsigned WORD_LSB  = $clog2(BE_W);  // Byte offset bits inside a word.
  localparam int unsigned MEM_WORDS = 1024;          // Bank depth.

  // Address increment of one word, sized to the bus.
  localparam logic [AW-1:0] WORD_STEP = AW'(BE_W);

  // Copy engine.
  localparam int unsigned LEN_W = 8;  // Copies of up to 255 words.

  // Peers sharing the bank.
  localparam int unsigned NB_PEERS = 2;
  localparam int unsigned SEL_W    = 1;

  localparam logic [SEL_W-1:0] CHAN_HOST   = 1'b0;  // External host port.
  localparam logic [SEL_W-1:0] CHAN_ENGINE = 1'b1;  // Block-copy engine.

  // Meaning of the wen strobe.
  typedef enum logic {
    BUS_WRITE = 1'b0,
    BUS_READ  = 1'b1
  } bus_op_e;

  // Copy engine FSM, three states per word.
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT,
    WRITE
  } engine_state_e;

  // Bank ownership FSM.
  typedef enum logic [1:0] {
    HOST,
    ARM,
    ENGINE
  } mode_state_e;

endpackage

// ==== hci_core_mux_static.sv ====
// Static multiplexer giving the whole bank port to one of NB_CHAN request channels.
`timescale 1ns/10ps

module hci_core_mux_static #(
  parameter int unsigned NB_CHAN = 2                                  // Number of channels.
) (
  // Channel side.
  input  logic                              in_req_i     [NB_CHAN],
  input  logic [hci_subsys_pkg::AW-1:0]     in_add_i     [NB_CHAN],
  input  logic                              in_wen_i     [NB_CHAN],
  input  logic [hci_subsys_pkg::DW-1:0]     in_data_i    [NB_CHAN],
  input  logic [hci_subsys_pkg::BE_W-1:0]   in_be_i      [NB_CHAN],
  output logic                              in_gnt_o     [NB_CHAN],
  output logic                              in_r_valid_o [NB_CHAN],
  output logic [hci_subsys_pkg::DW-1:0]     in_r_data_o  [NB_CHAN],

  // Owner of the bank.
  input  logic [$clog2(NB_CHAN)-1:0]        sel_i,

  // Bank side.
  output logic                              out_req_o,
  output logic [hci_subsys_pkg::AW-1:0]     out_add_o,
  output logic                              out_wen_o,
  output logic [hci_subsys_pkg::DW-1:0]     out_data_o,
  output logic [hci_subsys_pkg::BE_W-1:0]   out_be_o,
  input  logic                              out_gnt_i,
  input  logic                              out_r_valid_i,
  input  logic [hci_subsys_pkg::DW-1:0]     out_r_data_i
);

  // Request fields of the selected channel go straight to the bank.
  assign out_req_o  = in_req_i[sel_i];   // Only the owner can reach the bank.
  assign out_add_o  = in_add_i[sel_i];   // Byte address.
  assign out_wen_o  = in_wen_i[sel_i];   // 1 reads, 0 writes.
  assign out_data_o = in_data_i[sel_i];  // Write data.
  assign out_be_o   = in_be_i[sel_i];    // Byte lanes.

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan_rsp
    logic chan_sel;  // This channel currently owns the bank.

    assign chan_sel = (sel_i == ($clog2(NB_CHAN))'(ii));

    assign in_gnt_o[ii]     = chan_sel ? out_gnt_i : 1'b0;      // Grant to owner only.
    assign in_r_valid_o[ii] = chan_sel ? out_r_valid_i : 1'b0;  // Response to owner only.
    assign in_r_data_o[ii]  = out_r_data_i;                     // Data fanned out to all.
  end

endmodule

// ==== tcdm_bank.sv ====
// Single-ported word memory bank with byte enables and a one-cycle read response.
`timescale 1ns/10ps

module tcdm_bank (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              req_i,
  input  logic [hci_subsys_pkg::AW-1:0]     add_i,
  input  logic                              wen_i,
  input  logic [hci_subsys_pkg::DW-1:0]     data_i,
  input  logic [hci_subsys_pkg::BE_W-1:0]   be_i,
  output logic                              gnt_o,
  output logic                              r_valid_o,
  output logic [hci_subsys_pkg::DW-1:0]     r_data_o
);

  logic [hci_subsys_pkg::DW-1:0] mem_q [hci_subsys_pkg::MEM_WORDS];  // Storage array.

  logic [hci_subsys_pkg::AW-hci_subsys_pkg::WORD_LSB-1:0] word_idx;  // Word part of address.
  logic                                                   rd_taken;  // Read accepted now.
  logic                                                   wr_taken;  // Write accepted now.
  logic                                                   r_valid_q; // Response slot.
  logic [hci_subsys_pkg::DW-1:0]                          r_data_q;  // Registered read word.

  assign word_idx = add_i[hci_subsys_pkg::AW-1:hci_subsys_pkg::WORD_LSB];
  assign gnt_o    = req_i;  // Never busy, grant in the same cycle.
  assign rd_taken = req_i && (wen_i == hci_subsys_pkg::BUS_READ);
  assign wr_taken = req_i && (wen_i == hci_subsys_pkg::BUS_WRITE);

  // Array and read word, no reset needed on payload.
  always_ff @(posedge clk_i) begin
    if (wr_taken) begin
      for (int b = 0; b < hci_subsys_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx][b*hci_subsys_pkg::BW +: hci_subsys_pkg::BW] <=
            data_i[b*hci_subsys_pkg::BW +: hci_subsys_pkg::BW];  // Enabled lanes only.
        end
      end
    end
    if (rd_taken) begin
      r_data_q <= mem_q[word_idx];  // Old content, read before write.
    end
  end

  // Response valid one cycle after a taken read.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_taken;  // Single-cycle pulse per read.
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

// ==== hci_copy_engine.sv ====
// Block-copy engine moving a run of words by read, wait and write steps on its bus port.
`timescale 1ns/10ps

module hci_copy_engine (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               go_i,
  input  logic [hci_subsys_pkg::AW-1:0]      src_addr_i,
  input  logic [hci_subsys_pkg::AW-1:0]      dst_addr_i,
  input  logic [hci_subsys_pkg::LEN_W-1:0]   len_i,
  input  logic                               gnt_i,
  input  logic                               r_valid_i,
  input  logic [hci_subsys_pkg::DW-1:0]      r_data_i,
  output logic                               req_o,
  output logic [hci_subsys_pkg::AW-1:0]      add_o,
  output logic                               wen_o,
  output logic [hci_subsys_pkg::DW-1:0]      data_o,
  output logic [hci_subsys_pkg::BE_W-1:0]    be_o,
  output logic                               done_o
);

  hci_subsys_pkg::engine_state_e state_q;  // Current step.
  hci_subsys_pkg::engine_state_e state_d;  // Next step.

  logic [hci_subsys_pkg::AW-1:0]    src_q;      // Next source word.
  logic [hci_subsys_pkg::AW-1:0]    dst_q;      // Next destination word.
  logic [hci_subsys_pkg::LEN_W-1:0] cnt_q;      // Words still to move.
  logic [hci_subsys_pkg::DW-1:0]    buf_q;      // Word in transit.
  logic                             done_q;     // Completion pulse.
  logic                             start_cpy;  // Command with work to do.
  logic                             rd_taken;   // Source read accepted.
  logic                             wr_taken;   // Destination write accepted.
  logic                             last_word;  // Counter at the final word.

  assign start_cpy = (state_q == hci_subsys_pkg::IDLE) && go_i && (len_i != 0);
  assign rd_taken  = (state_q == hci_subsys_pkg::READ) && gnt_i;
  assign wr_taken  = (state_q == hci_subsys_pkg::WRITE) && gnt_i;
  assign last_word = (cnt_q == 1);

  // Next-state logic, every move out of a bus step waits for its grant.
  always_comb begin
    state_d = state_q;
    case (state_q)
      hci_subsys_pkg::IDLE: begin
        if (start_cpy) begin
          state_d = hci_subsys_pkg::READ;  // Zero length stays here.
        end
      end
      hci_subsys_pkg::READ: begin
        if (gnt_i) begin
          state_d = hci_subsys_pkg::WAIT;
        end
      end
      hci_subsys_pkg::WAIT: begin
        if (r_valid_i) begin
          state_d = hci_subsys_pkg::WRITE;  // Word captured in buffer.
        end
      end
      hci_subsys_pkg::WRITE: begin
        if (gnt_i) begin
          state_d = last_word ? hci_subsys_pkg::IDLE : hci_subsys_pkg::READ;
        end
      end
      default: state_d = hci_subsys_pkg::IDLE;
    endcase
  end

  // Control state.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= hci_subsys_pkg::IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= 1'b0;  // Default low, one-cycle pulse.
      if (state_q == hci_subsys_pkg::IDLE && go_i) begin
        cnt_q  <= len_i;          // Word count of the new command.
        done_q <= (len_i == 0);   // Empty copy finishes at once.
      end else if (wr_taken) begin
        cnt_q  <= cnt_q - 1;
        done_q <= last_word;      // Cycle after the last write.
      end
    end
  end

  // Address pointers and transit buffer.
  always_ff @(posedge clk_i) begin
    if (state_q == hci_subsys_pkg::IDLE && go_i) begin
      src_q <= src_addr_i;
      dst_q <= dst_addr_i;
    end else if (wr_taken) begin
      src_q <= src_q + hci_subsys_pkg::WORD_STEP;  // Both advance one word.
      dst_q <= dst_q + hci_subsys_pkg::WORD_STEP;
    end
    if (state_q == hci_subsys_pkg::WAIT && r_valid_i) begin
      buf_q <= r_data_i;
    end
  end

  // Bus port, read from source then write to destination.
  assign req_o  = (state_q == hci_subsys_pkg::READ) || (state_q == hci_subsys_pkg::WRITE);
  assign add_o  = (state_q == hci_subsys_pkg::WRITE) ? dst_q : src_q;
  assign wen_o  = (state_q == hci_subsys_pkg::WRITE) ? hci_subsys_pkg::BUS_WRITE
                                                     : hci_subsys_pkg::BUS_READ;
  assign data_o = buf_q;
  assign be_o   = {hci_subsys_pkg::BE_W{!rd_taken}};  // Full word on writes.
  assign done_o = done_q;

endmodule

// ==== hci_mode_ctrl.sv ====
// Mode controller owning the bank select and handing the bank between host and copy engine.
`timescale 1ns/10ps

module hci_mode_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               start_i,
  input  logic                               engine_done_i,
  output logic [hci_subsys_pkg::SEL_W-1:0]   sel_o,
  output logic                               go_o,
  output logic                               busy_o
);

  hci_subsys_pkg::mode_state_e state_q;  // Current owner phase.
  hci_subsys_pkg::mode_state_e state_d;  // Next owner phase.

  // HOST to ARM on start, ARM to ENGINE always, ENGINE to HOST on done.
  always_comb begin
    state_d = state_q;
    case (state_q)
      hci_subsys_pkg::HOST: begin
        if (start_i) begin
          state_d = hci_subsys_pkg::ARM;  // Only idle starts are taken.
        end
      end
      hci_subsys_pkg::ARM: begin
        state_d = hci_subsys_pkg::ENGINE;  // Host read in flight returns here.
      end
      hci_subsys_pkg::ENGINE: begin
        if (engine_done_i) begin
          state_d = hci_subsys_pkg::HOST;
        end
      end
      default: state_d = hci_subsys_pkg::HOST;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= hci_subsys_pkg::HOST;
    end else begin
      state_q <= state_d;
    end
  end

  assign sel_o  = (state_q == hci_subsys_pkg::ENGINE) ? hci_subsys_pkg::CHAN_ENGINE
                                                      : hci_subsys_pkg::CHAN_HOST;
  assign go_o   = (state_q == hci_subsys_pkg::ARM);   // Engine samples on the next edge.
  assign busy_o = (state_q != hci_subsys_pkg::HOST);  // Through the done cycle.

endmodule

// ==== hci_subsys_top.sv ====
// Top level of the shared-memory subsystem with host port, copy engine, controller, mux and bank.
`timescale 1ns/10ps

module hci_subsys_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               host_req_i,
  input  logic [hci_subsys_pkg::AW-1:0]      host_add_i,
  input  logic                               host_wen_i,
  input  logic [hci_subsys_pkg::DW-1:0]      host_data_i,
  input  logic [hci_subsys_pkg::BE_W-1:0]    host_be_i,
  output logic                               host_gnt_o,
  output logic                               host_r_valid_o,
  output logic [hci_subsys_pkg::DW-1:0]      host_r_data_o,
  input  logic                               start_i,
  input  logic [hci_subsys_pkg::AW-1:0]      src_addr_i,
  input  logic [hci_subsys_pkg::AW-1:0]      dst_addr_i,
  input  logic [hci_subsys_pkg::LEN_W-1:0]   len_i,
  output logic                               busy_o,
  output logic                               done_o
);

  // Channel side of the mux, indexed by channel number.
  logic                              chan_req     [hci_subsys_pkg::NB_PEERS];
  logic [hci_subsys_pkg::AW-1:0]     chan_add     [hci_subsys_pkg::NB_PEERS];
  logic                              chan_wen     [hci_subsys_pkg::NB_PEERS];
  logic [hci_subsys_pkg::DW-1:0]     chan_data    [hci_subsys_pkg::NB_PEERS];
  logic [hci_subsys_pkg::BE_W-1:0]   chan_be      [hci_subsys_pkg::NB_PEERS];
  logic                              chan_gnt     [hci_subsys_pkg::NB_PEERS];
  logic                              chan_r_valid [hci_subsys_pkg::NB_PEERS];
  logic [hci_subsys_pkg::DW-1:0]     chan_r_data  [hci_subsys_pkg::NB_PEERS];

  // Bank side of the mux.
  logic                              bank_req;
  logic [hci_subsys_pkg::AW-1:0]     bank_add;
  logic                              bank_wen;
  logic [hci_subsys_pkg::DW-1:0]     bank_data;
  logic [hci_subsys_pkg::BE_W-1:0]   bank_be;
  logic                              bank_gnt;
  logic                              bank_r_valid;
  logic [hci_subsys_pkg::DW-1:0]     bank_r_data;

  logic [hci_subsys_pkg::SEL_W-1:0]  sel;       // Bank owner.
  logic                              go;        // Engine launch pulse.
  logic                              busy;      // Copy phase, ARM included.
  logic                              eng_done;  // Engine completion pulse.

  // Host held off during the ARM cycle too, while sel still points at it.
  assign chan_req[hci_subsys_pkg::CHAN_HOST]  = host_req_i & ~busy;
  assign chan_add[hci_subsys_pkg::CHAN_HOST]  = host_add_i;
  assign chan_wen[hci_subsys_pkg::CHAN_HOST]  = host_wen_i;
  assign chan_data[hci_subsys_pkg::CHAN_HOST] = host_data_i;
  assign chan_be[hci_subsys_pkg::CHAN_HOST]   = host_be_i;
  assign host_gnt_o     = chan_gnt[hci_subsys_pkg::CHAN_HOST];
  assign host_r_valid_o = chan_r_valid[hci_subsys_pkg::CHAN_HOST];
  assign host_r_data_o  = chan_r_data[hci_subsys_pkg::CHAN_HOST];

  assign busy_o = busy;
  assign done_o = eng_done;

  hci_mode_ctrl hci_mode_ctrl_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start_i),
    .engine_done_i (eng_done),
    .sel_o         (sel),
    .go_o          (go),
    .busy_o        (busy)
  );

  hci_copy_engine hci_copy_engine_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .go_i       (go),
    .src_addr_i (src_addr_i),
    .dst_addr_i (dst_addr_i),
    .len_i      (len_i),
    .gnt_i      (chan_gnt[hci_subsys_pkg::CHAN_ENGINE]),
    .r_valid_i  (chan_r_valid[hci_subsys_pkg::CHAN_ENGINE]),
    .r_data_i   (chan_r_data[hci_subsys_pkg::CHAN_ENGINE]),
    .req_o      (chan_req[hci_subsys_pkg::CHAN_ENGINE]),
    .add_o      (chan_add[hci_subsys_pkg::CHAN_ENGINE]),
    .wen_o      (chan_wen[hci_subsys_pkg::CHAN_ENGINE]),
    .data_o     (chan_data[hci_subsys_pkg::CHAN_ENGINE]),
    .be_o       (chan_be[hci_subsys_pkg::CHAN_ENGINE]),
    .done_o     (eng_done)
  );

  hci_core_mux_static #(
    .NB_CHAN (hci_subsys_pkg::NB_PEERS)
  ) hci_core_mux_static_i (
    .in_req_i      (chan_req),
    .in_add_i      (chan_add),
    .in_wen_i      (chan_wen),
    .in_data_i     (chan_data),
    .in_be_i       (chan_be),
    .in_gnt_o      (chan_gnt),
    .in_r_valid_o  (chan_r_valid),
    .in_r_data_o   (chan_r_data),
    .sel_i         (sel),
    .out_req_o     (bank_req),
    .out_add_o     (bank_add),
    .out_wen_o     (bank_wen),
    .out_data_o    (bank_data),
    .out_be_o      (bank_be),
    .out_gnt_i     (bank_gnt),
    .out_r_valid_i (bank_r_valid),
    .out_r_data_i  (bank_r_data)
  );

  tcdm_bank tcdm_bank_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (bank_req),
    .add_i     (bank_add),
    .wen_i     (bank_wen),
    .data_i    (bank_data),
    .be_i      (bank_be),
    .gnt_o     (bank_gnt),
    .r_valid_o (bank_r_valid),
    .r_data_o  (bank_r_data)
  );

endmodule

// ==== hci_subsys_properties.sv ====
// Concurrent assertions on bank ownership, done pulse, read response timing and reset state.
`timescale 1ns/10ps

module hci_subsys_properties (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              host_gnt_o,
  input logic                              host_wen_i,
  input logic                              host_r_valid_o,
  input logic                              busy_o,
  input logic                              done_o,
  input logic [hci_subsys_pkg::SEL_W-1:0]  sel
);

  // Engine owns the bank, host is shut out.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_gnt_o && sel == hci_subsys_pkg::CHAN_ENGINE))
    else $error("host grant while engine owns the bank");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) done_o |=> !done_o)
    else $error("done_o longer than one cycle");

  // Host read answered in the next cycle, ARM included.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (host_gnt_o && host_wen_i) |=> host_r_valid_o)
    else $error("host read without r_valid one cycle later");

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !busy_o)
    else $error("busy_o high after reset");

endmodule

bind hci_subsys_top hci_subsys_properties hci_subsys_properties_i (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .host_gnt_o     (host_gnt_o),
  .host_wen_i     (host_wen_i),
  .host_r_valid_o (host_r_valid_o),
  .busy_o         (busy_o),
  .done_o         (done_o),
  .sel            (sel)
);

// ==== tb_hci_subsys.sv ====
// Testbench that reads the stim file, drives host accesses and copy commands, and checks results.
`timescale 1ns/10ps

module tb_hci_subsys;

  localparam int MAX_TESTS = 64;  // Stim lines kept.

  logic                                   clk_i = 1'b0;
  logic                                   rst_n_i;
  logic                                   host_req_i;
  logic [hci_subsys_pkg::AW-1:0]          host_add_i;
  logic                                   host_wen_i;
  logic [hci_subsys_pkg::DW-1:0]          host_data_i;
  logic [hci_subsys_pkg::BE_W-1:0]        host_be_i;
  logic                                   host_gnt_o;
  logic                                   host_r_valid_o;
  logic [hci_subsys_pkg::DW-1:0]          host_r_data_o;
  logic                                   start_i;
  logic [hci_subsys_pkg::AW-1:0]          src_addr_i;
  logic [hci_subsys_pkg::AW-1:0]          dst_addr_i;
  logic [hci_subsys_pkg::LEN_W-1:0]       len_i;
  logic                                   busy_o;
  logic                                   done_o;

  reg   [8*16-1:0] t_name [MAX_TESTS];     // Test names.
  reg   [7:0]      t_op   [MAX_TESTS];     // Opcode letters.
  logic [31:0]     t_f    [MAX_TESTS][7];  // Numeric fields.
  int              n_tests   = 0;
  int              errors    = 0;
  int              limit     = 300;  // Grows with every copy line.
  int              cycle_cnt = 0;

  hci_subsys_top hci_subsys_top_i (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period.

  // Run limit.
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit) begin
      $display("ERROR: run did not finish within %0d cycles", limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic value_error(input [8*16-1:0] name, input [31:0] exp, input [31:0] act);
    $display("FAILED %0s expected %h actual %h", name, exp, act);
    errors++;
  endtask

  task automatic word_error(input [8*16-1:0] name, input string what);
    $display("ERROR %0s: %s", name, what);
    errors++;
  endtask

  // One host access, ends 0.5 ns after a rising edge.
  task automatic host_access(input [8*16-1:0] name, input logic wen, input logic [31:0] add,
                             input logic [31:0] data, input logic [31:0] be,
                             input logic [31:0] exp);
    int waited;
    bit got_gnt;
    waited      = 0;
    host_req_i  = 1'b1;
    host_wen_i  = wen;
    host_add_i  = add[hci_subsys_pkg::AW-1:0];
    host_data_i = data;
    host_be_i   = be[hci_subsys_pkg::BE_W-1:0];
    @(negedge clk_i);
    while (!host_gnt_o && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    got_gnt = host_gnt_o;  // Mid-cycle, before the edge takes it.
    @(posedge clk_i);
    #0.5;
    host_req_i = 1'b0;
    if (!got_gnt) begin
      word_error(name, "host request was never granted");
    end else if (wen) begin
      @(negedge clk_i);  // Response slot.
      if (!host_r_valid_o) begin
        word_error(name, "no r_valid one cycle after the read grant");
      end else if (host_r_data_o !== exp) begin
        value_error(name, exp, host_r_data_o);
      end
      @(posedge clk_i);
      #0.5;
    end
  endtask

  // Copy command, with a held host read and a second start for H lines.
  task automatic run_copy(input int t);
    int k;
    int lat;
    bit host_on;
    bit host_pend;
    bit granted;
    bit rsp_pend;
    host_on    = (t_op[t] == "H");
    lat        = -1;
    granted    = 1'b0;
    rsp_pend   = 1'b0;
    start_i    = 1'b1;
    src_addr_i = t_f[t][0][hci_subsys_pkg::AW-1:0];
    dst_addr_i = t_f[t][1][hci_subsys_pkg::AW-1:0];
    len_i      = t_f[t][2][hci_subsys_pkg::LEN_W-1:0];
    @(posedge clk_i);  // Start sampled here.
    #0.5;
    start_i   = 1'b0;
    host_pend = host_on;
    if (host_on) begin
      host_req_i = 1'b1;
      host_wen_i = 1'b1;
      host_add_i = t_f[t][4][hci_subsys_pkg::AW-1:0];
      host_be_i  = '1;
    end
    for (k = 0; k < 3 * t_f[t][2] + 20 && (lat < 0 || host_pend || rsp_pend); k++) begin
      @(negedge clk_i);
      if (rsp_pend) begin
        rsp_pend = 1'b0;
        if (!host_r_valid_o) begin
          word_error(t_name[t], "held host read got no r_valid");
        end else if (host_r_data_o !== t_f[t][5]) begin
          value_error(t_name[t], t_f[t][5], host_r_data_o);
        end
      end
      if (lat < 0 && !busy_o) begin
        word_error(t_name[t], "busy_o low before done_o");
      end
      if (lat < 0 && done_o) begin
        lat = k;
      end
      if (host_pend && (host_gnt_o !== !busy_o)) begin
        word_error(t_name[t], "host_gnt_o not granted exactly when busy_o fell");
      end
      granted = host_pend && host_gnt_o;
      @(posedge clk_i);
      #0.5;
      if (granted) begin
        host_req_i = 1'b0;
        host_pend  = 1'b0;
        rsp_pend   = 1'b1;
      end
      if (host_on && k == 1) begin
        start_i    = 1'b1;  // Second start while busy.
        dst_addr_i = t_f[t][6][hci_subsys_pkg::AW-1:0];
      end
      if (k == 2) begin
        start_i = 1'b0;
      end
    end
    start_i    = 1'b0;
    host_req_i = 1'b0;
    if (lat < 0) begin
      word_error(t_name[t], "done_o never pulsed");
    end else if (lat != t_f[t][3]) begin
      value_error(t_name[t], t_f[t][3], lat);
    end
    if (host_pend || rsp_pend) begin
      word_error(t_name[t], "held host read did not complete");
    end
  endtask

  initial begin
    int          fd;
    int          cnt;
    int          errs_before;
    int          n_fail;
    reg [8*160-1:0] line;
    reg [8*16-1:0]  name;
    reg [7:0]       op;
    logic [31:0]    f [7];
    n_fail      = 0;
    rst_n_i     = 1'b0;
    host_req_i  = 1'b0;
    host_add_i  = '0;
    host_wen_i  = 1'b1;
    host_data_i = '0;
    host_be_i   = '0;
    start_i     = 1'b0;
    src_addr_i  = '0;
    dst_addr_i  = '0;
    len_i       = '0;
    void'($urandom(32'h7c66_15a7));
    fd = $fopen("hci_subsys_stim.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open hci_subsys_stim.txt");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = '0;
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h", name, op,
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        if (cnt == 9 && name != "//") begin  // Column lines fail the number fields.
          t_name[n_tests] = name;
          t_op[n_tests]   = op;
          t_f[n_tests]    = f;
          if (op == "C" || op == "H") begin
            limit += 3 * f[2] + 20;
          end
          n_tests++;
        end
      end
      $fclose(fd);
    end
    repeat (8) @(posedge clk_i);
    #0.5;
    rst_n_i = 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      repeat ($urandom_range(3, 0)) begin
        @(posedge clk_i);
        #0.5;
      end
      errs_before = errors;
      case (t_op[t])
        "W":     host_access(t_name[t], 1'b0, t_f[t][0], t_f[t][1], t_f[t][2], 32'h0);
        "R":     host_access(t_name[t], 1'b1, t_f[t][0], 32'h0, 32'hf, t_f[t][1]);
        "C":     run_copy(t);
        "H":     run_copy(t);
        default: word_error(t_name[t], "unknown opcode in stim file");
      endcase
      if (errors == errs_before) begin
        $display("PASS %0s", t_name[t]);
      end else begin
        $display("FAIL %0s", t_name[t]);
        n_fail++;
      end
    end
    $display("Summary: %0d tests run, %0d failed, %0d errors", n_tests, n_fail, errors);
    if (errors == 0 && n_tests > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== hci_subsys_stim.txt ====
// name op f0 f1 f2 f3 f4 f5 f6, numbers in hex
// W addr data be, R addr expected, C/H src dst len done_latency host_addr host_expected dst2
wr_word      W 010 11223344 f 0 0 0 0
rd_word      R 010 11223344 0 0 0 0 0
be_full      W 020 aabbccdd f 0 0 0 0
be_partial   W 020 00112200 6 0 0 0 0
be_check     R 020 aa1122dd 0 0 0 0 0
src_w0       W 100 a0a0a0a0 f 0 0 0 0
src_w1       W 104 b1b1b1b1 f 0 0 0 0
src_w2       W 108 c2c2c2c2 f 0 0 0 0
src_w3       W 10c d3d3d3d3 f 0 0 0 0
copy4        C 100 200 4 d 0 0 0
copy4_r0     R 200 a0a0a0a0 0 0 0 0 0
copy4_r1     R 204 b1b1b1b1 0 0 0 0 0
copy4_r2     R 208 c2c2c2c2 0 0 0 0 0
copy4_r3     R 20c d3d3d3d3 0 0 0 0 0
old_word     W 300 5a5a0001 f 0 0 0 0
hold_copy    H 104 240 2 7 010 11223344 300
hold_r0      R 240 b1b1b1b1 0 0 0 0 0
hold_r1      R 244 c2c2c2c2 0 0 0 0 0
ignored_dst  R 300 5a5a0001 0 0 0 0 0
zero_old     W 380 cafe0380 f 0 0 0 0
zero_copy    C 100 380 0 1 0 0 0
zero_check   R 380 cafe0380 0 0 0 0 0

// ==== tb.f ====
hci_subsys_pkg.sv
hci_core_mux_static.sv
tcdm_bank.sv
hci_copy_engine.sv
hci_mode_ctrl.sv
hci_subsys_top.sv
hci_subsys_properties.sv
tb_hci_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hci_subsys
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
